/* project.f */
rtl/eeprom_pkg.sv
rtl/i2c_bit_engine.sv
rtl/eeprom_ctrl.sv
rtl/eeprom_if_top.sv
tb/eeprom_model.sv
tb/tb_eeprom_if.sv

/* run_sim.sh */
#!/bin/sh
# build and run the eeprom interface testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/10ps \
    -f project.f --top-module tb_eeprom_if -Mdir obj_dir -o sim_eeprom
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/sim_eeprom > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "^NO ERRORS$" sim.log; then
    echo "simulation passed"
    exit 0
else
    echo "simulation failed"
    exit 1
fi

/* tb/tb_eeprom_if.sv */
`timescale 1ns/10ps

module tb_eeprom_if;
    import eeprom_pkg::*;

    localparam int n_random       = 16;
    localparam int timeout_cycles = 20000;   // ~40 transactions of up to 220 cycles, doubled

    logic              CLK;
    logic              RESET;
    logic              wr;
    logic              rd;
    logic [addr_w-1:0] addr;
    logic [data_w-1:0] data_drv;
    logic              data_oe;
    logic              refuse_ack;
    logic              ack;
    logic              nak;
    wire               scl;
    tri1               sda;
    tri1 [data_w-1:0]  data;

    logic [data_w-1:0] shadow [0:(1<<addr_w)-1];
    logic [addr_w-1:0] wr_addrs [$];
    logic              in_txn;
    int                errors;
    int                cycles;
    int                acks;
    int                txns;

    assign data = data_oe ? data_drv : {data_w{1'bz}};

    eeprom_if_top i_dut (
        .CLK   (CLK),
        .RESET (RESET),
        .wr    (wr),
        .rd    (rd),
        .addr  (addr),
        .data  (data),
        .ack   (ack),
        .nak   (nak),
        .scl   (scl),
        .sda   (sda)
    );

    eeprom_model i_mem (
        .CLK        (CLK),
        .refuse_ack (refuse_ack),
        .scl        (scl),
        .sda        (sda)
    );

    initial begin
        CLK = 1'b0;
        forever #10 CLK = ~CLK;
    end

    function automatic logic [data_w-1:0] fill_value(input logic [addr_w-1:0] a);
        return a[data_w-1:0] ^ {a[addr_w-1:data_w], 5'h15};
    endfunction

    task automatic check_value(input string name, input logic [15:0] expected,
                               input logic [15:0] actual);
        assert (expected == actual) else begin
            errors++;
            $display("FAIL %s expected %h got %h", name, expected, actual);
        end
    endtask

    task automatic finish_run(input logic timed_out);
        int total;
        total = errors + i_mem.errors;
        $display("error count: testbench %0d, model %0d", errors, i_mem.errors);
        if (timed_out || total != 0)
            $display("ERRORS FOUND");
        else
            $display("NO ERRORS");
        $finish;
    endtask

    // raise the request, hold it until ack, return what the DUT answered
    task automatic run_txn(input logic do_wr, input logic do_rd, input logic [addr_w-1:0] a,
                           input logic [data_w-1:0] d, output logic [data_w-1:0] got,
                           output logic got_nak);
        @(negedge CLK);
        addr     = a;
        wr       = do_wr;
        rd       = do_rd;
        data_drv = d;
        data_oe  = do_wr;
        in_txn   = 1'b1;
        txns++;
        @(negedge CLK);
        while (!ack)
            @(negedge CLK);
        got     = data;
        got_nak = nak;
        wr      = 1'b0;
        rd      = 1'b0;
        data_oe = 1'b0;
        if (!got_nak) begin
            check_value("model address", 16'(a), 16'(i_mem.last_addr));
            check_value("model read bit", 16'(!do_wr), 16'(i_mem.saw_read));
        end
        @(negedge CLK);
        in_txn = 1'b0;   // bus back to idle from the next edge on
    endtask

    task automatic write_byte(input logic [addr_w-1:0] a, input logic [data_w-1:0] d,
                              input logic with_rd);
        logic [data_w-1:0] got;
        logic              got_nak;
        run_txn(1'b1, with_rd, a, d, got, got_nak);
        check_value("nak", 16'(refuse_ack), 16'(got_nak));
        if (!refuse_ack)
            shadow[a] = d;
    endtask

    task automatic read_check(input logic [addr_w-1:0] a);
        logic [data_w-1:0] got;
        logic              got_nak;
        run_txn(1'b0, 1'b1, a, 8'h00, got, got_nak);
        check_value("nak", 16'h0, 16'(got_nak));
        check_value("data", 16'(shadow[a]), 16'(got));
    endtask

    always @(posedge CLK) begin
        cycles <= cycles + 1;
        if (ack)
            acks <= acks + 1;
        if (cycles == timeout_cycles) begin
            $display("timeout after %0d cycles, transaction never acknowledged", cycles);
            finish_run(1'b1);
        end
    end

    a_idle_levels: assert property (
        @(posedge CLK) disable iff (RESET)
        !in_txn |-> scl && sda && !ack && !nak && data == {data_w{1'b1}}
    ) else begin
        errors++;
        $display("scl, sda, ack, nak or data not at idle level between transactions");
    end

    a_ack_one_cycle: assert property (
        @(posedge CLK) disable iff (RESET)
        ack |=> !ack
    ) else begin
        errors++;
        $display("ack stayed high for more than one cycle");
    end

    a_nak_only_with_ack: assert property (
        @(posedge CLK) disable iff (RESET)
        nak |-> ack
    ) else begin
        errors++;
        $display("nak high outside the ack cycle");
    end

    a_stop_before_ack: assert property (
        @(posedge CLK) disable iff (RESET)
        ack |-> !i_mem.in_xfer
    ) else begin
        errors++;
        $display("ack came before the bus saw a stop condition");
    end

    initial begin
        logic [addr_w-1:0] a;
        logic [data_w-1:0] d;
        void'($urandom(32'h808b));
        RESET = 1'b1;
        wr = 1'b0;
        rd = 1'b0;
        addr = '0;
        data_drv = '0;
        data_oe = 1'b0;
        refuse_ack = 1'b0;
        in_txn = 1'b0;
        errors = 0;
        cycles = 0;
        acks = 0;
        txns = 0;
        for (int i = 0; i < (1 << addr_w); i++) begin
            a = addr_w'(i);
            shadow[a] = fill_value(a);
        end
        repeat (2) @(negedge CLK);
        RESET = 1'b0;

        write_byte(11'h123, 8'ha5, 1'b0);
        read_check(11'h123);
        read_check(11'h7fe);   // untouched, fill pattern

        // two per block, all written before the first read back
        for (int i = 0; i < n_random; i++) begin
            a = {3'(i), 8'($urandom)};
            d = 8'($urandom);
            write_byte(a, d, 1'b0);
            wr_addrs.push_back(a);
        end
        foreach (wr_addrs[i])
            read_check(wr_addrs[i]);

        refuse_ack = 1'b1;
        write_byte(wr_addrs[0], ~shadow[wr_addrs[0]], 1'b0);
        refuse_ack = 1'b0;
        read_check(wr_addrs[0]);

        // wr and rd together, write wins
        write_byte(11'h5c3, 8'h3c, 1'b1);
        read_check(11'h5c3);

        @(negedge CLK);
        check_value("ack pulses", 16'(txns), 16'(acks));
        finish_run(1'b0);
    end

endmodule

/* tb/eeprom_model.sv */
`timescale 1ns/10ps

module eeprom_model (
    input  logic CLK,
    input  logic refuse_ack,
    inout  wire  scl,
    inout  wire  sda
);
    import eeprom_pkg::*;

    typedef enum logic [2:0] {m_idle, m_ctrl, m_addr, m_wdata, m_rdata, m_wait} phase_e;

    logic [data_w-1:0] mem [0:(1<<addr_w)-1];
    phase_e            phase;
    logic              scl_p;
    logic              sda_p;
    logic              drive_low;
    logic [3:0]        bit_cnt;
    logic [3:0]        bit_at_rise;   // bit count when scl last went high
    logic [data_w-1:0] shreg;
    logic [data_w-1:0] rd_byte;
    logic [2:0]        block;
    logic              ack_it;
    logic              check_nack;
    logic              have_addr;
    logic              wr_pending;
    logic [data_w-1:0] wr_data;
    logic              in_xfer;
    logic              saw_read;
    logic [addr_w-1:0] last_addr;
    int                errors;

    assign sda = drive_low ? 1'b0 : 1'bz;

    initial begin
        logic [addr_w-1:0] a;
        for (int i = 0; i < (1 << addr_w); i++) begin
            a = addr_w'(i);
            mem[a] = a[data_w-1:0] ^ {a[addr_w-1:data_w], 5'h15};
        end
        phase = m_idle;
        scl_p = 1'b1;
        sda_p = 1'b1;
        drive_low = 1'b0;
        bit_cnt = '0;
        bit_at_rise = '0;
        shreg = '0;
        rd_byte = '0;
        block = '0;
        ack_it = 1'b0;
        check_nack = 1'b0;
        have_addr = 1'b0;
        wr_pending = 1'b0;
        wr_data = '0;
        in_xfer = 1'b0;
        saw_read = 1'b0;
        last_addr = '0;
        errors = 0;
    end

    task automatic take_byte(input logic [data_w-1:0] b);
        ack_it     = !refuse_ack;
        check_nack = 1'b0;
        case (phase)
            m_ctrl: begin
                assert (b[7:4] == dev_type) else begin
                    errors++;
                    $display("FAIL control byte type expected %h got %h", dev_type, b[7:4]);
                end
                if (!b[0]) begin
                    block = b[3:1];
                    phase = ack_it ? m_addr : m_wait;
                end else begin
                    assert (have_addr) else begin
                        errors++;
                        $display("read control byte came before any word address");
                    end
                    assert (b[3:1] == block) else begin
                        errors++;
                        $display("FAIL read block bits expected %h got %h", block, b[3:1]);
                    end
                    saw_read = 1'b1;
                    rd_byte  = mem[last_addr];
                    phase    = ack_it ? m_rdata : m_wait;
                end
            end
            m_addr: begin
                last_addr = {block, b};
                have_addr = 1'b1;
                phase     = m_wdata;
            end
            m_wdata: begin
                wr_data    = b;
                wr_pending = 1'b1;
                phase      = m_wait;
            end
            m_rdata: begin
                ack_it     = 1'b0;   // ninth bit belongs to the master
                check_nack = 1'b1;
                phase      = m_wait;
            end
            default: ack_it = 1'b0;
        endcase
    endtask

    task automatic bus_start();
        assert (bit_at_rise == 4'd0) else begin
            errors++;
            $display("sda fell while scl high in the middle of a byte");
        end
        assert (!in_xfer || (have_addr && !wr_pending && phase == m_wdata)) else begin
            errors++;
            $display("start inside a transaction that never saw a stop");
        end
        if (!in_xfer)
            saw_read = 1'b0;
        in_xfer = 1'b1;
        phase   = m_ctrl;
        bit_cnt = '0;
    endtask

    task automatic bus_stop();
        assert (bit_at_rise == 4'd0 && phase != m_rdata) else begin
            errors++;
            $display("sda rose while scl high in the middle of a byte");
        end
        if (wr_pending)
            mem[last_addr] = wr_data;   // commit on stop, like the real part
        in_xfer    = 1'b0;
        have_addr  = 1'b0;
        wr_pending = 1'b0;
        phase      = m_idle;
        bit_cnt    = '0;
    endtask

    task automatic scl_rise(input logic sda_s);
        bit_at_rise = bit_cnt;
        if (bit_cnt == 4'd8) begin
            if (check_nack) begin
                assert (sda_s) else begin
                    errors++;
                    $display("master acknowledged the last read byte");
                end
            end
            check_nack = 1'b0;
            bit_cnt    = '0;
        end else if (phase != m_idle && phase != m_wait) begin
            shreg   = {shreg[data_w-2:0], sda_s};
            bit_cnt = bit_cnt + 4'd1;
            if (bit_cnt == 4'd8)
                take_byte(shreg);
        end
    endtask

    task automatic scl_fall();
        if (bit_cnt == 4'd8) begin
            drive_low = ack_it;
        end else if (phase == m_rdata) begin
            drive_low = ~rd_byte[data_w-1];   // msb first
            rd_byte   = {rd_byte[data_w-2:0], 1'b0};
        end else begin
            drive_low = 1'b0;
        end
    endtask

    // bus lines move on posedge, so look at them half a cycle later
    always @(negedge CLK) begin
        logic scl_s;
        logic sda_s;
        scl_s = scl;
        sda_s = sda;
        if (scl_p && scl_s && sda_p && !sda_s)
            bus_start();
        else if (scl_p && scl_s && !sda_p && sda_s)
            bus_stop();
        else if (!scl_p && scl_s)
            scl_rise(sda_s);
        else if (scl_p && !scl_s)
            scl_fall();
        scl_p = scl_s;
        sda_p = sda_s;
    end

endmodule

/* rtl/eeprom_if_top.sv */
`timescale 1ns/10ps

module eeprom_if_top (
    input  logic                          CLK,
    input  logic                          RESET,
    input  logic                          wr,
    input  logic                          rd,
    input  logic [eeprom_pkg::addr_w-1:0] addr,
    inout  wire  [eeprom_pkg::data_w-1:0] data,
    output logic                          ack,
    output logic                          nak,
    output logic                          scl,
    inout  wire                           sda
);
    import eeprom_pkg::*;

    logic              cmd_valid;
    bus_cmd_e          cmd;
    logic [data_w-1:0] tx_byte;
    logic              master_ack;
    logic              busy;
    logic              done;
    logic [data_w-1:0] rx_byte;
    logic              slave_ack;
    logic              sda_drive_low;
    logic [data_w-1:0] data_rd;
    logic              data_rd_oe;

    // open drain, pull-up is on the board
    assign sda  = sda_drive_low ? 1'b0 : 1'bz;
    assign data = data_rd_oe ? data_rd : {data_w{1'bz}};

    eeprom_ctrl i_ctrl (
        .CLK        (CLK),
        .RESET      (RESET),
        .wr         (wr),
        .rd         (rd),
        .addr       (addr),
        .data_wr    (data),
        .busy       (busy),
        .done       (done),
        .rx_byte    (rx_byte),
        .slave_ack  (slave_ack),
        .cmd_valid  (cmd_valid),
        .cmd        (cmd),
        .tx_byte    (tx_byte),
        .master_ack (master_ack),
        .ack        (ack),
        .nak        (nak),
        .data_rd    (data_rd),
        .data_rd_oe (data_rd_oe)
    );

    i2c_bit_engine i_engine (
        .CLK           (CLK),
        .RESET         (RESET),
        .cmd_valid     (cmd_valid),
        .cmd           (cmd),
        .tx_byte       (tx_byte),
        .master_ack    (master_ack),
        .sda_in        (sda),
        .scl           (scl),
        .sda_drive_low (sda_drive_low),
        .busy          (busy),
        .done          (done),
        .rx_byte       (rx_byte),
        .slave_ack     (slave_ack)
    );

endmodule

/* rtl/eeprom_ctrl.sv */
`timescale 1ns/10ps

module eeprom_ctrl (
    input  logic                          CLK,
    input  logic                          RESET,
    input  logic                          wr,
    input  logic                          rd,
    input  logic [eeprom_pkg::addr_w-1:0] addr,
    input  logic [eeprom_pkg::data_w-1:0] data_wr,
    input  logic                          busy,
    input  logic                          done,
    input  logic [eeprom_pkg::data_w-1:0] rx_byte,
    input  logic                          slave_ack,
    output logic                          cmd_valid,
    output eeprom_pkg::bus_cmd_e          cmd,
    output logic [eeprom_pkg::data_w-1:0] tx_byte,
    output logic                          master_ack,
    output logic                          ack,
    output logic                          nak,
    output logic [eeprom_pkg::data_w-1:0] data_rd,
    output logic                          data_rd_oe
);
    import eeprom_pkg::*;

    typedef enum logic [3:0] {
        st_idle,
        st_write_start,
        st_ctrl_write,
        st_addr_write,
        st_data_write,
        st_read_start,
        st_ctrl_read,
        st_data_read,
        st_stop,
        st_done
    } state_e;

    state_e            state;
    state_e            next_state;
    logic              issued;     // command of this state already sent
    logic              is_read;
    logic              nak_flag;
    logic              byte_nak;
    logic [addr_w-1:0] addr_q;
    logic [data_w-1:0] data_q;

    assign byte_nak = (cmd == cmd_write) && !slave_ack;

    // where to go once the engine reports done
    always_comb begin
        next_state = st_stop;   // also the exit on a missing ack
        case (state)
            st_write_start: next_state = st_ctrl_write;
            st_ctrl_write:  if (slave_ack) next_state = st_addr_write;
            st_addr_write:  if (slave_ack) next_state = is_read ? st_read_start : st_data_write;
            st_read_start:  next_state = st_ctrl_read;
            st_ctrl_read:   if (slave_ack) next_state = st_data_read;
            st_stop:        next_state = st_done;
            default:        next_state = st_stop;
        endcase
    end

    // command and byte for the current state
    always_comb begin
        cmd        = cmd_write;
        tx_byte    = addr_q[data_w-1:0];
        master_ack = 1'b0;   // single byte read ends with nack
        case (state)
            st_write_start, st_read_start: cmd = cmd_start;
            st_ctrl_write: tx_byte = {dev_type, addr_q[addr_w-1:data_w], 1'b0};
            st_ctrl_read:  tx_byte = {dev_type, addr_q[addr_w-1:data_w], 1'b1};
            st_data_write: tx_byte = data_q;
            st_data_read:  cmd = cmd_read;
            st_stop:       cmd = cmd_stop;
            default:       cmd = cmd_write;
        endcase
    end

    always_ff @(posedge CLK) begin
        if (RESET) begin
            state     <= st_idle;
            issued    <= 1'b0;
            cmd_valid <= 1'b0;
            is_read   <= 1'b0;
            nak_flag  <= 1'b0;
        end else begin
            cmd_valid <= 1'b0;
            case (state)
                st_idle: begin
                    issued <= 1'b0;
                    if (wr || rd) begin
                        is_read  <= !wr;   // write wins
                        nak_flag <= 1'b0;
                        state    <= st_write_start;
                    end
                end
                st_done: state <= st_idle;
                default: begin
                    if (!issued && !busy) begin
                        cmd_valid <= 1'b1;
                        issued    <= 1'b1;
                    end else if (issued && done) begin
                        issued <= 1'b0;
                        state  <= next_state;
                        if (byte_nak)
                            nak_flag <= 1'b1;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge CLK) begin
        if (state == st_idle && (wr || rd)) begin
            addr_q <= addr;
            data_q <= data_wr;
        end
        if (state == st_data_read && issued && done)
            data_rd <= rx_byte;
    end

    assign ack        = (state == st_done);
    assign nak        = ack && nak_flag;
    assign data_rd_oe = ack && is_read && !nak_flag;

    // ack only right after the engine finished a stop
    a_ack_single: assert property (
        @(posedge CLK) disable iff (RESET)
        ack |-> $past(done && cmd == cmd_stop)
    ) else $error("ack without a completed stop condition");

    // a returned byte needs an acknowledged read control byte
    a_oe_with_ack: assert property (
        @(posedge CLK) disable iff (RESET)
        data_rd_oe |-> slave_ack
    ) else $error("data bus driven after an unacknowledged read");

endmodule

/* rtl/i2c_bit_engine.sv */
`timescale 1ns/10ps

module i2c_bit_engine (
    input  logic                          CLK,
    input  logic                          RESET,
    input  logic                          cmd_valid,
    input  eeprom_pkg::bus_cmd_e          cmd,
    input  logic [eeprom_pkg::data_w-1:0] tx_byte,
    input  logic                          master_ack,
    input  logic                          sda_in,
    output logic                          scl,
    output logic                          sda_drive_low,
    output logic                          busy,
    output logic                          done,
    output logic [eeprom_pkg::data_w-1:0] rx_byte,
    output logic                          slave_ack
);
    import eeprom_pkg::*;

    localparam int q_w    = $clog2(bit_clks);
    localparam int q_rise = bit_clks / 2 - 1;   // last low quarter
    localparam int q_samp = bit_clks / 2;       // first high quarter
    localparam int q_last = bit_clks - 1;
    localparam int b_w    = $clog2(data_w + 1);

    logic [q_w-1:0]    quarter;
    logic [b_w-1:0]    bit_cnt;
    bus_cmd_e          cur_cmd;
    logic [data_w-1:0] shift_out;
    logic              ack_bit;
    logic              ack_slot;
    logic              framing;
    logic              last_q;
    logic              next_low;

    assign ack_slot = (bit_cnt == b_w'(data_w));   // ninth bit
    assign framing  = (cur_cmd == cmd_start) || (cur_cmd == cmd_stop);
    assign last_q   = (quarter == q_w'(q_last));

    // sda level for the coming bit, applied at the end of quarter 0
    always_comb begin
        case (cur_cmd)
            cmd_start: next_low = 1'b0;             // release before scl rises
            cmd_stop:  next_low = 1'b1;             // low before scl rises
            cmd_write: next_low = ack_slot ? 1'b0 : ~shift_out[data_w-1];
            default:   next_low = ack_slot ? ack_bit : 1'b0;
        endcase
    end

    always_ff @(posedge CLK) begin
        if (RESET) begin
            busy          <= 1'b0;
            done          <= 1'b0;
            quarter       <= '0;
            bit_cnt       <= '0;
            cur_cmd       <= cmd_stop;
            scl           <= 1'b1;
            sda_drive_low <= 1'b0;
        end else begin
            done <= 1'b0;
            if (!busy) begin
                if (cmd_valid) begin
                    busy    <= 1'b1;
                    cur_cmd <= cmd;
                    quarter <= '0;
                    bit_cnt <= '0;
                    scl     <= 1'b0;   // quarter 0 is low
                end
            end else begin
                quarter <= quarter + 1'b1;
                if (quarter == '0)
                    sda_drive_low <= next_low;
                if (quarter == q_w'(q_rise))
                    scl <= 1'b1;
                // start and stop move sda in the middle of the high phase
                if (framing && quarter == q_w'(q_samp))
                    sda_drive_low <= (cur_cmd == cmd_start);
                if (last_q) begin
                    if (framing || ack_slot) begin
                        busy <= 1'b0;
                        done <= 1'b1;   // scl stays high until the next command
                    end else begin
                        scl     <= 1'b0;
                        bit_cnt <= bit_cnt + 1'b1;
                    end
                end
            end
        end
    end

    // shift registers and sampled acknowledge
    always_ff @(posedge CLK) begin
        if (!busy && cmd_valid) begin
            shift_out <= tx_byte;
            ack_bit   <= master_ack;
        end else if (busy && quarter == q_w'(q_samp)) begin
            if (cur_cmd == cmd_read && !ack_slot)
                rx_byte <= {rx_byte[data_w-2:0], sda_in};   // msb first
            if (cur_cmd == cmd_write && ack_slot)
                slave_ack <= ~sda_in;
        end else if (busy && last_q && cur_cmd == cmd_write) begin
            shift_out <= shift_out << 1;
        end
    end

    // the controller waits for done before the next command
    a_no_cmd_while_busy: assert property (
        @(posedge CLK) disable iff (RESET)
        cmd_valid |-> !busy
    ) else $error("cmd_valid while bit engine busy");

    // data bits only move under scl low, start and stop are the exceptions
    a_sda_only_scl_low: assert property (
        @(posedge CLK) disable iff (RESET)
        $changed(sda_drive_low) |-> !scl || (busy && framing)
    ) else $error("sda changed while scl high outside start/stop");

endmodule

/* rtl/eeprom_pkg.sv */
package eeprom_pkg;

    // host side
    localparam int addr_w = 11;                // 2048 bytes, blocks in bits 10..8
    localparam int data_w = 8;

    // control byte layout: dev_type, block bits, r/w bit
    localparam logic [3:0] dev_type = 4'b1010;

    // four quarter phases per bus bit, scl low for the first two
    localparam int bit_clks = 4;

    // commands from the transaction FSM to the bit engine
    typedef enum logic [1:0] {
        cmd_start = 2'd0,   // also the repeated start
        cmd_stop  = 2'd1,
        cmd_write = 2'd2,   // byte out, then sample slave ack
        cmd_read  = 2'd3    // byte in, then drive master ack
    } bus_cmd_e;

endpackage
